// ==== common/mips_id_pkg.sv ====
package mips_id_pkg;

	typedef logic [4:0]  reg_addr_t;
	typedef logic [31:0] word_t;

	localparam reg_addr_t LINK_REG    = 5'd31;
	localparam word_t     LINK_OFFSET = 32'd8; // return address is pc + 8

	//////////////////////////////////////////////////////////////////////
	// primary opcodes
	//////////////////////////////////////////////////////////////////////
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_REGIMM  = 6'b000001;
	localparam logic [5:0] OP_J       = 6'b000010;
	localparam logic [5:0] OP_JAL     = 6'b000011;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;
	localparam logic [5:0] OP_BLEZ    = 6'b000110;
	localparam logic [5:0] OP_BGTZ    = 6'b000111;
	localparam logic [5:0] OP_ADDI    = 6'b001000;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_SLTI    = 6'b001010;
	localparam logic [5:0] OP_SLTIU   = 6'b001011;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;
	localparam logic [5:0] OP_COP0    = 6'b010000;
	localparam logic [5:0] OP_LB      = 6'b100000;
	localparam logic [5:0] OP_LH      = 6'b100001;
	localparam logic [5:0] OP_LW      = 6'b100011;
	localparam logic [5:0] OP_LBU     = 6'b100100;
	localparam logic [5:0] OP_LHU     = 6'b100101;
	localparam logic [5:0] OP_SB      = 6'b101000;
	localparam logic [5:0] OP_SH      = 6'b101001;
	localparam logic [5:0] OP_SW      = 6'b101011;

	// SPECIAL function field
	localparam logic [5:0] F_SLL     = 6'b000000;
	localparam logic [5:0] F_SRL     = 6'b000010;
	localparam logic [5:0] F_SRA     = 6'b000011;
	localparam logic [5:0] F_SLLV    = 6'b000100;
	localparam logic [5:0] F_SRLV    = 6'b000110;
	localparam logic [5:0] F_SRAV    = 6'b000111;
	localparam logic [5:0] F_JR      = 6'b001000;
	localparam logic [5:0] F_JALR    = 6'b001001;
	localparam logic [5:0] F_SYSCALL = 6'b001100;
	localparam logic [5:0] F_BREAK   = 6'b001101;
	localparam logic [5:0] F_MFHI    = 6'b010000;
	localparam logic [5:0] F_MTHI    = 6'b010001;
	localparam logic [5:0] F_MFLO    = 6'b010010;
	localparam logic [5:0] F_MTLO    = 6'b010011;
	localparam logic [5:0] F_MULT    = 6'b011000;
	localparam logic [5:0] F_MULTU   = 6'b011001;
	localparam logic [5:0] F_DIV     = 6'b011010;
	localparam logic [5:0] F_DIVU    = 6'b011011;
	localparam logic [5:0] F_ADD     = 6'b100000;
	localparam logic [5:0] F_ADDU    = 6'b100001;
	localparam logic [5:0] F_SUB     = 6'b100010;
	localparam logic [5:0] F_SUBU    = 6'b100011;
	localparam logic [5:0] F_AND     = 6'b100100;
	localparam logic [5:0] F_OR      = 6'b100101;
	localparam logic [5:0] F_XOR     = 6'b100110;
	localparam logic [5:0] F_NOR     = 6'b100111;
	localparam logic [5:0] F_SLT     = 6'b101010;
	localparam logic [5:0] F_SLTU    = 6'b101011;
	localparam logic [5:0] F_ERET    = 6'b011000; // under COP0 with CO set

	// REGIMM rt field
	localparam logic [4:0] RI_BLTZ   = 5'b00000;
	localparam logic [4:0] RI_BGEZ   = 5'b00001;
	localparam logic [4:0] RI_BLTZAL = 5'b10000;
	localparam logic [4:0] RI_BGEZAL = 5'b10001;

	// COP0 rs field
	localparam logic [4:0] CP0_MF = 5'b00000;
	localparam logic [4:0] CP0_MT = 5'b00100;
	localparam logic [4:0] CP0_CO = 5'b10000;

	//////////////////////////////////////////////////////////////////////
	// instruction formats
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm;
	} i_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] index;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} inst_t;

	// funct for R-type, opcode for immediate ops
	typedef logic [5:0] alu_op_t;
	localparam alu_op_t ALU_NONE     = 6'b111111;
	localparam alu_op_t ALU_ADDR_ADD = 6'b001001;

	typedef enum logic [1:0] {SEL1_REG, SEL1_PC, SEL1_SHAMT} vsrc1_sel_t;
	typedef enum logic [1:0] {SEL2_REG, SEL2_SIGN_IMM, SEL2_ZERO_IMM, SEL2_LINK} vsrc2_sel_t;
	typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_t;

	typedef struct packed {
		logic      load;
		logic      store;
		mem_size_t size;
		logic      is_unsigned;
	} mem_op_t;

	typedef struct packed {
		logic b;        // any conditional branch
		logic beq;
		logic bne;
		logic bgz;      // taken when greater than zero
		logic bez;      // taken when equal to zero
		logic blz;      // taken when less than zero
		logic jump;
		logic jump_reg;
	} branch_t;

	typedef struct packed {
		alu_op_t    alu_op;
		logic       arith_unsigned;
		logic       mult;
		logic       div;
		mem_op_t    mem;
		branch_t    br;
		reg_addr_t  src1;
		reg_addr_t  src2;
		reg_addr_t  dest;
		vsrc1_sel_t vsrc1_sel;
		vsrc2_sel_t vsrc2_sel;
		logic       eret;
		logic       mtc0;
		logic       mfc0;
		logic       mthi;
		logic       mtlo;
		logic       syscall;
		logic       brk;
		logic       goto_mem;
		logic       goto_hilo;
		logic       goto_wb;
		logic       no_inst;
	} dec_ctrl_t;

	typedef struct packed {
		word_t       pc;
		logic        delay_slot;
		word_t       vsrc1;
		word_t       vsrc2;
		word_t       reg1_rt;   // branch compare operands
		word_t       reg2_rt;
		logic [25:0] j_index;
		word_t       jr_target;
	} id_out_t;

endpackage

// ==== logic/inst_latch.sv ====
module inst_latch #(
	parameter mips_id_pkg::word_t RESET_PC = 32'hbfc00000
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               stall,
	input  logic               clear,
	input  logic               inst_valid,
	input  mips_id_pkg::word_t if_pc,
	input  logic               if_delay_slot,
	input  mips_id_pkg::inst_t inst,
	output logic               inst_ack,
	output mips_id_pkg::word_t pc,
	output logic               delay_slot,
	output mips_id_pkg::inst_t id_inst
);

	// ready when not held, flushed or in reset
	assign inst_ack = ~(stall | clear | ~arst_n);

	//////////////////////////////////////////////////////////////////////
	// stage register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc         <= RESET_PC;
			id_inst    <= '0; // nop
			delay_slot <= 1'b0;
		end else if (clear) begin // flush beats stall
			pc         <= RESET_PC;
			id_inst    <= '0;
			delay_slot <= 1'b0;
		end else if (inst_valid && inst_ack) begin
			pc         <= if_pc;
			id_inst    <= inst;
			delay_slot <= if_delay_slot;
		end
	end

endmodule

// ==== decode/inst_decoder.sv ====
module inst_decoder (
	input  mips_id_pkg::inst_t     id_inst,
	output mips_id_pkg::dec_ctrl_t ctrl
);

	logic [5:0] op;
	logic [5:0] fn;
	mips_id_pkg::reg_addr_t rs;
	mips_id_pkg::reg_addr_t rt;
	mips_id_pkg::reg_addr_t rd;
	logic [4:0] sa;
	logic rs_z, rt_z, rd_z, sa_z;

	// instruction classes
	logic arith_r, logic_r, shift_sa, shift_v, mul, dv;
	logic arith_i, logic_i, lui;
	logic beq, bne, blez, bgtz, bltz, bgez, bltzal, bgezal;
	logic j, jal, jr, jalr;
	logic mfhi, mflo, mthi, mtlo, syscall, brk;
	logic load, store, eret, mfc0, mtc0;
	logic mem_unsigned;
	mips_id_pkg::mem_size_t mem_size;

	logic uns, link, known;
	logic alu_r, rd_rs, rd_rt, wr_rd, wr_rt;

	assign op = id_inst.r.opcode;
	assign fn = id_inst.r.funct;
	assign rs = id_inst.r.rs;
	assign rt = id_inst.r.rt;
	assign rd = id_inst.r.rd;
	assign sa = id_inst.r.shamt;

	assign rs_z = rs == 5'd0;
	assign rt_z = rt == 5'd0;
	assign rd_z = rd == 5'd0;
	assign sa_z = sa == 5'd0;

	//////////////////////////////////////////////////////////////////////
	// recognition, reserved fields must be zero
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		{arith_r, logic_r, shift_sa, shift_v, mul, dv, arith_i, logic_i, lui} = '0;
		{beq, bne, blez, bgtz, bltz, bgez, bltzal, bgezal, j, jal, jr, jalr} = '0;
		{mfhi, mflo, mthi, mtlo, syscall, brk, load, store, eret, mfc0, mtc0} = '0;
		mem_unsigned = 1'b0;
		mem_size = mips_id_pkg::MEM_WORD;
		case (op)
			mips_id_pkg::OP_SPECIAL: begin
				case (fn)
					mips_id_pkg::F_ADD, mips_id_pkg::F_ADDU, mips_id_pkg::F_SUB,
					mips_id_pkg::F_SUBU, mips_id_pkg::F_SLT, mips_id_pkg::F_SLTU:
						arith_r = sa_z;
					mips_id_pkg::F_AND, mips_id_pkg::F_OR, mips_id_pkg::F_XOR,
					mips_id_pkg::F_NOR:
						logic_r = sa_z;
					mips_id_pkg::F_SLL, mips_id_pkg::F_SRL, mips_id_pkg::F_SRA:
						shift_sa = rs_z;
					mips_id_pkg::F_SLLV, mips_id_pkg::F_SRLV, mips_id_pkg::F_SRAV:
						shift_v = sa_z;
					mips_id_pkg::F_MULT, mips_id_pkg::F_MULTU: mul = rd_z && sa_z;
					mips_id_pkg::F_DIV, mips_id_pkg::F_DIVU:   dv = rd_z && sa_z;
					mips_id_pkg::F_JR:      jr = rt_z && rd_z && sa_z;
					mips_id_pkg::F_JALR:    jalr = rt_z && sa_z;
					mips_id_pkg::F_MFHI:    mfhi = rs_z && rt_z && sa_z;
					mips_id_pkg::F_MFLO:    mflo = rs_z && rt_z && sa_z;
					mips_id_pkg::F_MTHI:    mthi = rt_z && rd_z && sa_z;
					mips_id_pkg::F_MTLO:    mtlo = rt_z && rd_z && sa_z;
					mips_id_pkg::F_SYSCALL: syscall = 1'b1; // code field is free
					mips_id_pkg::F_BREAK:   brk = 1'b1;
					default: ;
				endcase
			end
			mips_id_pkg::OP_REGIMM: begin
				case (rt)
					mips_id_pkg::RI_BLTZ:   bltz = 1'b1;
					mips_id_pkg::RI_BGEZ:   bgez = 1'b1;
					mips_id_pkg::RI_BLTZAL: bltzal = 1'b1;
					mips_id_pkg::RI_BGEZAL: bgezal = 1'b1;
					default: ;
				endcase
			end
			mips_id_pkg::OP_J:    j = 1'b1;
			mips_id_pkg::OP_JAL:  jal = 1'b1;
			mips_id_pkg::OP_BEQ:  beq = 1'b1;
			mips_id_pkg::OP_BNE:  bne = 1'b1;
			mips_id_pkg::OP_BLEZ: blez = rt_z;
			mips_id_pkg::OP_BGTZ: bgtz = rt_z;
			mips_id_pkg::OP_ADDI, mips_id_pkg::OP_ADDIU, mips_id_pkg::OP_SLTI,
			mips_id_pkg::OP_SLTIU:
				arith_i = 1'b1;
			mips_id_pkg::OP_ANDI, mips_id_pkg::OP_ORI, mips_id_pkg::OP_XORI:
				logic_i = 1'b1;
			mips_id_pkg::OP_LUI:  lui = rs_z;
			mips_id_pkg::OP_COP0: begin
				case (rs)
					mips_id_pkg::CP0_MF: mfc0 = sa_z && fn[5:3] == 3'd0;
					mips_id_pkg::CP0_MT: mtc0 = sa_z && fn[5:3] == 3'd0;
					mips_id_pkg::CP0_CO: eret = rt_z && rd_z && sa_z && fn == mips_id_pkg::F_ERET;
					default: ;
				endcase
			end
			mips_id_pkg::OP_LB: begin
				load = 1'b1;
				mem_size = mips_id_pkg::MEM_BYTE;
			end
			mips_id_pkg::OP_LBU: begin
				load = 1'b1;
				mem_size = mips_id_pkg::MEM_BYTE;
				mem_unsigned = 1'b1;
			end
			mips_id_pkg::OP_LH: begin
				load = 1'b1;
				mem_size = mips_id_pkg::MEM_HALF;
			end
			mips_id_pkg::OP_LHU: begin
				load = 1'b1;
				mem_size = mips_id_pkg::MEM_HALF;
				mem_unsigned = 1'b1;
			end
			mips_id_pkg::OP_LW: load = 1'b1;
			mips_id_pkg::OP_SB: begin
				store = 1'b1;
				mem_size = mips_id_pkg::MEM_BYTE;
			end
			mips_id_pkg::OP_SH: begin
				store = 1'b1;
				mem_size = mips_id_pkg::MEM_HALF;
			end
			mips_id_pkg::OP_SW: store = 1'b1;
			default: ;
		endcase
	end

	assign uns = ((arith_r | mul | dv) && fn inside {mips_id_pkg::F_ADDU, mips_id_pkg::F_SUBU,
		mips_id_pkg::F_SLTU, mips_id_pkg::F_MULTU, mips_id_pkg::F_DIVU})
		|| (arith_i && op inside {mips_id_pkg::OP_ADDIU, mips_id_pkg::OP_SLTIU});

	assign link  = jal | jalr | bltzal | bgezal; // writes pc + 8
	assign alu_r = arith_r | logic_r | shift_sa | shift_v;
	assign rd_rs = arith_r | logic_r | shift_v | mul | dv | arith_i | logic_i | beq | bne
		| blez | bgtz | bltz | bgez | bltzal | bgezal | jr | jalr | load | store | mthi | mtlo;
	assign rd_rt = arith_r | logic_r | shift_sa | shift_v | mul | dv | beq | bne | store | mtc0;
	assign wr_rd = alu_r | jalr | mfhi | mflo;
	assign wr_rt = arith_i | logic_i | lui | load | mfc0;
	assign known = alu_r | rd_rs | wr_rt | link | j | mfhi | mflo | syscall | brk | eret | mtc0;

	//////////////////////////////////////////////////////////////////////
	// control word
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		ctrl = '0;
		if (alu_r)
			ctrl.alu_op = fn;
		else if (arith_i | logic_i | lui)
			ctrl.alu_op = op;
		else if (load | store | jr | link)
			ctrl.alu_op = mips_id_pkg::ALU_ADDR_ADD;
		else
			ctrl.alu_op = mips_id_pkg::ALU_NONE;

		ctrl.arith_unsigned = uns;
		ctrl.mult = mul;
		ctrl.div  = dv;

		ctrl.mem.load        = load;
		ctrl.mem.store       = store;
		ctrl.mem.size        = mem_size;
		ctrl.mem.is_unsigned = mem_unsigned;

		ctrl.br.b        = beq | bne | blez | bgtz | bltz | bgez | bltzal | bgezal;
		ctrl.br.beq      = beq;
		ctrl.br.bne      = bne;
		ctrl.br.bgz      = bgtz | bgez | bgezal;
		ctrl.br.bez      = blez | bgez | bgezal;
		ctrl.br.blz      = blez | bltz | bltzal;
		ctrl.br.jump     = j | jal;
		ctrl.br.jump_reg = jr | jalr;

		ctrl.src1 = rd_rs ? rs : 5'd0;
		ctrl.src2 = rd_rt ? rt : 5'd0;
		if (wr_rd)
			ctrl.dest = rd;
		else if (wr_rt)
			ctrl.dest = rt;
		else if (link)
			ctrl.dest = mips_id_pkg::LINK_REG;

		if (link)
			ctrl.vsrc1_sel = mips_id_pkg::SEL1_PC;
		else if (shift_sa)
			ctrl.vsrc1_sel = mips_id_pkg::SEL1_SHAMT;
		else
			ctrl.vsrc1_sel = mips_id_pkg::SEL1_REG;

		if (load | store | arith_i)
			ctrl.vsrc2_sel = mips_id_pkg::SEL2_SIGN_IMM;
		else if (logic_i | lui)
			ctrl.vsrc2_sel = mips_id_pkg::SEL2_ZERO_IMM;
		else if (link)
			ctrl.vsrc2_sel = mips_id_pkg::SEL2_LINK;
		else
			ctrl.vsrc2_sel = mips_id_pkg::SEL2_REG;

		ctrl.eret    = eret;
		ctrl.mtc0    = mtc0;
		ctrl.mfc0    = mfc0;
		ctrl.mthi    = mthi;
		ctrl.mtlo    = mtlo;
		ctrl.syscall = syscall;
		ctrl.brk     = brk;

		ctrl.goto_mem  = load | store;
		ctrl.goto_hilo = mul | dv | mthi | mtlo;
		ctrl.goto_wb   = ctrl.dest != 5'd0; // writes to $0 are dropped
		ctrl.no_inst   = ~known;
	end

endmodule

// ==== decode/operand_select.sv ====
module operand_select (
	input  mips_id_pkg::inst_t     id_inst,
	input  mips_id_pkg::word_t     pc,
	input  logic                   delay_slot,
	input  mips_id_pkg::dec_ctrl_t ctrl,
	input  mips_id_pkg::word_t     reg_rdata1,
	input  mips_id_pkg::word_t     reg_rdata2,
	output mips_id_pkg::id_out_t   out
);

	mips_id_pkg::word_t sign_imm;
	mips_id_pkg::word_t zero_imm;
	mips_id_pkg::word_t shamt;

	assign sign_imm = {{16{id_inst.i.imm[15]}}, id_inst.i.imm};
	assign zero_imm = {16'd0, id_inst.i.imm};
	assign shamt    = {27'd0, id_inst.r.shamt};

	//////////////////////////////////////////////////////////////////////
	// ALU operand muxes
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (ctrl.vsrc1_sel)
			mips_id_pkg::SEL1_PC:    out.vsrc1 = pc;    // link base
			mips_id_pkg::SEL1_SHAMT: out.vsrc1 = shamt;
			default:                 out.vsrc1 = reg_rdata1;
		endcase
	end

	always_comb begin
		case (ctrl.vsrc2_sel)
			mips_id_pkg::SEL2_SIGN_IMM: out.vsrc2 = sign_imm;
			mips_id_pkg::SEL2_ZERO_IMM: out.vsrc2 = zero_imm;
			mips_id_pkg::SEL2_LINK:     out.vsrc2 = mips_id_pkg::LINK_OFFSET;
			default:                    out.vsrc2 = reg_rdata2;
		endcase
	end

	// pass-through for the branch unit and later stages
	assign out.pc         = pc;
	assign out.delay_slot = delay_slot;
	assign out.reg1_rt    = reg_rdata1;
	assign out.reg2_rt    = reg_rdata2;
	assign out.j_index    = id_inst.j.index;
	assign out.jr_target  = reg_rdata1; // rs of jr/jalr

endmodule

// ==== logic/id_stage.sv ====
module id_stage #(
	parameter mips_id_pkg::word_t RESET_PC = 32'hbfc00000
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   stall,
	input  logic                   clear,
	input  mips_id_pkg::word_t     if_pc,
	input  logic                   if_delay_slot,
	input  mips_id_pkg::inst_t     inst,
	input  logic                   inst_valid,
	input  mips_id_pkg::word_t     reg_rdata1,
	input  mips_id_pkg::word_t     reg_rdata2,
	output logic                   inst_ack,
	output logic                   next_delay_slot,
	output mips_id_pkg::reg_addr_t reg_raddr1,
	output mips_id_pkg::reg_addr_t reg_raddr2,
	output mips_id_pkg::dec_ctrl_t ctrl,
	output mips_id_pkg::id_out_t   out
);

	mips_id_pkg::word_t pc;
	mips_id_pkg::inst_t id_inst;
	logic               delay_slot;

	inst_latch #(
		.RESET_PC(RESET_PC)
	) inst_latch_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.stall        (stall),
		.clear        (clear),
		.inst_valid   (inst_valid),
		.if_pc        (if_pc),
		.if_delay_slot(if_delay_slot),
		.inst         (inst),
		.inst_ack     (inst_ack),
		.pc           (pc),
		.delay_slot   (delay_slot),
		.id_inst      (id_inst)
	);

	inst_decoder inst_decoder_inst (
		.id_inst(id_inst),
		.ctrl   (ctrl)
	);

	operand_select operand_select_inst (
		.id_inst   (id_inst),
		.pc        (pc),
		.delay_slot(delay_slot),
		.ctrl      (ctrl),
		.reg_rdata1(reg_rdata1),
		.reg_rdata2(reg_rdata2),
		.out       (out)
	);

	//////////////////////////////////////////////////////////////////////
	// register file read and fetch feedback
	//////////////////////////////////////////////////////////////////////
	assign reg_raddr1 = ctrl.src1;
	assign reg_raddr2 = ctrl.src2;

	// instruction after any branch or jump sits in its delay slot
	assign next_delay_slot = ctrl.br.b | ctrl.br.jump | ctrl.br.jump_reg;

endmodule

// ==== verification/id_stage_asserts.sv ====
module id_stage_asserts (
	input logic                   clk,
	input logic                   arst_n,
	input logic                   stall,
	input logic                   clear,
	input logic                   inst_ack,
	input mips_id_pkg::word_t     pc,
	input mips_id_pkg::inst_t     id_inst,
	input mips_id_pkg::dec_ctrl_t ctrl
);

	int fail_count = 0; // failed assertions so far

	// no acknowledge while held or flushed
	ack_blocked: assert property (@(posedge clk) (stall || clear) |-> !inst_ack)
		else begin
			$error("inst_ack high during stall or clear");
			fail_count++;
		end

	hold_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
		(stall && !clear) |=> ($stable(pc) && $stable(id_inst)))
		else begin
			$error("stage register changed under stall");
			fail_count++;
		end

	unknown_is_inert: assert property (@(posedge clk) disable iff (!arst_n)
		ctrl.no_inst |-> (ctrl.alu_op == mips_id_pkg::ALU_NONE && ctrl.dest == 5'd0))
		else begin
			$error("unknown instruction carries an alu op or destination");
			fail_count++;
		end

endmodule

bind id_stage id_stage_asserts id_stage_asserts_inst (
	.clk     (clk),
	.arst_n  (arst_n),
	.stall   (stall),
	.clear   (clear),
	.inst_ack(inst_ack),
	.pc      (pc),
	.id_inst (id_inst),
	.ctrl    (ctrl)
);

// ==== verification/id_stage_tb.sv ====
module id_stage_tb;

	localparam int          CLK_PERIOD      = 100;
	localparam int          DRIVE_DELAY     = 10;
	localparam int          RESET_CYCLES    = 16;
	localparam int          NUM_ROWS        = 15;
	localparam int          WATCHDOG_CYCLES = NUM_ROWS * 4 + RESET_CYCLES;
	localparam logic [31:0] BOOT_PC         = 32'hbfc00000;
	localparam logic [5:0]  ADDR_ADD        = mips_id_pkg::ALU_ADDR_ADD;
	localparam logic [5:0]  NO_ALU          = mips_id_pkg::ALU_NONE;

	typedef struct packed {
		logic        stall;
		logic        clear;
		logic        valid;
		logic        rnd;     // register data from the LFSR
		logic [31:0] inst;
		logic [31:0] pc;
		logic        ds;
		logic [31:0] rd1;
		logic [31:0] rd2;
		logic        ack;
		logic [31:0] e_pc;
		logic        no_inst;
		logic [5:0]  alu_op;
		logic [4:0]  dest;
		logic [4:0]  raddr1;
		logic [4:0]  raddr2;
		logic [31:0] vsrc1;
		logic [31:0] vsrc2;
		logic [4:0]  mem;     // load store size unsigned
		logic [7:0]  br;      // b beq bne bgz bez blz jump jump_reg
		logic        nds;
		logic [31:0] jr;
	} row_t;

	logic                   clk;
	logic                   arst_n;
	logic                   stall;
	logic                   clear;
	logic [31:0]            if_pc;
	logic                   if_delay_slot;
	mips_id_pkg::inst_t     inst;
	logic                   inst_valid;
	logic [31:0]            reg_rdata1;
	logic [31:0]            reg_rdata2;
	logic                   inst_ack;
	logic                   next_delay_slot;
	logic [4:0]             reg_raddr1;
	logic [4:0]             reg_raddr2;
	mips_id_pkg::dec_ctrl_t ctrl;
	mips_id_pkg::id_out_t   out;

	row_t        rows [NUM_ROWS];
	logic [31:0] lfsr;
	logic        held_ds; // delay-slot flag the latch should hold
	string       phase;

	id_stage #(
		.RESET_PC(BOOT_PC)
	) id_stage_inst (
		.clk            (clk),
		.arst_n         (arst_n),
		.stall          (stall),
		.clear          (clear),
		.if_pc          (if_pc),
		.if_delay_slot  (if_delay_slot),
		.inst           (inst),
		.inst_valid     (inst_valid),
		.reg_rdata1     (reg_rdata1),
		.reg_rdata2     (reg_rdata2),
		.inst_ack       (inst_ack),
		.next_delay_slot(next_delay_slot),
		.reg_raddr1     (reg_raddr1),
		.reg_raddr2     (reg_raddr2),
		.ctrl           (ctrl),
		.out            (out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_word(output logic [31:0] w);
		for (int b = 0; b < 32; b++) begin
			lfsr = lfsr_step(lfsr);
			w[b] = lfsr[0];
		end
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s %s is %h, expected %h", $time, phase, what, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus and expected values
	//////////////////////////////////////////////////////////////////////
	task automatic fill_table();
		// idle after reset, nop in the latch
		rows[0] = '{1'b0, 1'b0, 1'b0, 1'b0, 32'h00000000, 32'h00000000, 1'b0,
			32'h11110001, 32'h22220002,
			1'b1, BOOT_PC, 1'b0, 6'h00, 5'd0, 5'd0, 5'd0, 32'h00000000, 32'h22220002,
			5'b00000, 8'h00, 1'b0, 32'h11110001};
		rows[1] = '{1'b0, 1'b0, 1'b1, 1'b0, 32'h00221821, 32'hbfc00004, 1'b0, // addu $3,$1,$2
			32'h00000010, 32'hfffffff0,
			1'b1, 32'hbfc00004, 1'b0, 6'h21, 5'd3, 5'd1, 5'd2, 32'h00000010, 32'hfffffff0,
			5'b00000, 8'h00, 1'b0, 32'h00000010};
		rows[2] = '{1'b0, 1'b0, 1'b1, 1'b0, 32'h000429c0, 32'hbfc00008, 1'b0, // sll $5,$4,7
			32'h0bad0001, 32'h000000f0,
			1'b1, 32'hbfc00008, 1'b0, 6'h00, 5'd5, 5'd0, 5'd4, 32'h00000007, 32'h000000f0,
			5'b00000, 8'h00, 1'b0, 32'h0bad0001};
		rows[3] = '{1'b0, 1'b0, 1'b1, 1'b0, 32'h2528fffc, 32'hbfc0000c, 1'b0, // addiu $8,$9,-4
			32'h00001000, 32'h55555555,
			1'b1, 32'hbfc0000c, 1'b0, 6'h09, 5'd8, 5'd9, 5'd0, 32'h00001000, 32'hfffffffc,
			5'b00000, 8'h00, 1'b0, 32'h00001000};
		rows[4] = '{1'b0, 1'b0, 1'b1, 1'b0, 32'h356a8001, 32'hbfc00010, 1'b0, // ori $10,$11
			32'h00ff0000, 32'haaaaaaaa,
			1'b1, 32'hbfc00010, 1'b0, 6'h0d, 5'd10, 5'd11, 5'd0, 32'h00ff0000, 32'h00008001,
			5'b00000, 8'h00, 1'b0, 32'h00ff0000};
		// stalled, ori stays
		rows[5] = '{1'b1, 1'b0, 1'b1, 1'b0, 32'h8dacfff0, 32'hbfc00014, 1'b0,
			32'h00ff0000, 32'haaaaaaaa,
			1'b0, 32'hbfc00010, 1'b0, 6'h0d, 5'd10, 5'd11, 5'd0, 32'h00ff0000, 32'h00008001,
			5'b00000, 8'h00, 1'b0, 32'h00ff0000};
		rows[6] = '{1'b0, 1'b0, 1'b1, 1'b0, 32'h8dacfff0, 32'hbfc00014, 1'b0, // lw $12,-16($13)
			32'h80000100, 32'h33333333,
			1'b1, 32'hbfc00014, 1'b0, ADDR_ADD, 5'd12, 5'd13, 5'd0, 32'h80000100, 32'hfffffff0,
			5'b10100, 8'h00, 1'b0, 32'h80000100};
		rows[7] = '{1'b0, 1'b0, 1'b1, 1'b0, 32'ha1ee0003, 32'hbfc00018, 1'b0, // sb $14,3($15)
			32'h10000000, 32'h000000ab,
			1'b1, 32'hbfc00018, 1'b0, ADDR_ADD, 5'd0, 5'd15, 5'd14, 32'h10000000, 32'h00000003,
			5'b01000, 8'h00, 1'b0, 32'h10000000};
		rows[8] = '{1'b0, 1'b0, 1'b0, 1'b0, 32'h00000000, 32'h00000000, 1'b0, // no request
			32'h10000000, 32'h000000ab,
			1'b1, 32'hbfc00018, 1'b0, ADDR_ADD, 5'd0, 5'd15, 5'd14, 32'h10000000, 32'h00000003,
			5'b01000, 8'h00, 1'b0, 32'h10000000};
		rows[9] = '{1'b0, 1'b0, 1'b1, 1'b1, 32'h0cf00040, 32'hbfc0001c, 1'b0, // jal
			32'h00000000, 32'h00000000,
			1'b1, 32'hbfc0001c, 1'b0, ADDR_ADD, 5'd31, 5'd0, 5'd0, 32'hbfc0001c, 32'h00000008,
			5'b00000, 8'h02, 1'b1, 32'h00000000};
		rows[10] = '{1'b0, 1'b0, 1'b1, 1'b0, 32'h02000008, 32'hbfc00020, 1'b1, // jr $16
			32'h80002000, 32'h13579bdf,
			1'b1, 32'hbfc00020, 1'b0, ADDR_ADD, 5'd0, 5'd16, 5'd0, 32'h80002000, 32'h13579bdf,
			5'b00000, 8'h01, 1'b1, 32'h80002000};
		rows[11] = '{1'b0, 1'b0, 1'b1, 1'b0, 32'h1232fffe, 32'hbfc00024, 1'b0, // beq $17,$18
			32'h00000042, 32'h00000042,
			1'b1, 32'hbfc00024, 1'b0, NO_ALU, 5'd0, 5'd17, 5'd18, 32'h00000042, 32'h00000042,
			5'b00000, 8'hc0, 1'b1, 32'h00000042};
		rows[12] = '{1'b0, 1'b0, 1'b1, 1'b1, 32'h06710040, 32'hbfc00028, 1'b0, // bgezal $19
			32'h00000000, 32'h00000000,
			1'b1, 32'hbfc00028, 1'b0, ADDR_ADD, 5'd31, 5'd19, 5'd0, 32'hbfc00028, 32'h00000008,
			5'b00000, 8'h98, 1'b1, 32'h00000000};
		rows[13] = '{1'b0, 1'b0, 1'b1, 1'b0, 32'hfc001234, 32'hbfc0002c, 1'b0, // opcode 0x3f
			32'hdeadbeef, 32'hcafef00d,
			1'b1, 32'hbfc0002c, 1'b1, NO_ALU, 5'd0, 5'd0, 5'd0, 32'hdeadbeef, 32'hcafef00d,
			5'b00000, 8'h00, 1'b0, 32'hdeadbeef};
		// flush back to the boot pc, beats the pending request
		rows[14] = '{1'b0, 1'b1, 1'b1, 1'b0, 32'h00221821, 32'hbfc00030, 1'b0,
			32'h44440004, 32'h77770007,
			1'b0, BOOT_PC, 1'b0, 6'h00, 5'd0, 5'd0, 5'd0, 32'h00000000, 32'h77770007,
			5'b00000, 8'h00, 1'b0, 32'h44440004};
	endtask

	task automatic apply_row(input row_t r);
		logic [31:0] d1;
		logic [31:0] d2;
		d1 = r.rd1;
		d2 = r.rd2;
		if (r.rnd) begin
			rand_word(d1);
			rand_word(d2);
		end
		@(posedge clk);
		#DRIVE_DELAY;
		stall         = r.stall;
		clear         = r.clear;
		inst_valid    = r.valid;
		inst          = r.inst;
		if_pc         = r.pc;
		if_delay_slot = r.ds;
		reg_rdata1    = d1;
		reg_rdata2    = d2;
		@(negedge clk);
		check(32'(inst_ack), 32'(r.ack), "inst_ack");
		@(posedge clk); // transfer edge
		#DRIVE_DELAY;
		stall      = 1'b0;
		clear      = 1'b0;
		inst_valid = 1'b0;
		if (r.clear)
			held_ds = 1'b0;
		else if (r.valid && r.ack)
			held_ds = r.ds;
		@(negedge clk);
		check(out.pc, r.e_pc, "pc");
		check(32'(out.delay_slot), 32'(held_ds), "delay_slot");
		check(32'(ctrl.no_inst), 32'(r.no_inst), "no_inst");
		check(32'(ctrl.alu_op), 32'(r.alu_op), "alu_op");
		check(32'(ctrl.dest), 32'(r.dest), "dest");
		check(32'(reg_raddr1), 32'(r.raddr1), "reg_raddr1");
		check(32'(reg_raddr2), 32'(r.raddr2), "reg_raddr2");
		check(out.vsrc1, r.vsrc1, "vsrc1");
		check(out.vsrc2, r.vsrc2, "vsrc2");
		check(out.reg1_rt, d1, "reg1_rt");
		check(out.reg2_rt, d2, "reg2_rt");
		check({30'd0, ctrl.mem.load, ctrl.mem.store}, {30'd0, r.mem[4:3]}, "load/store");
		if (r.mem[4] || r.mem[3])
			check({27'd0, ctrl.mem}, {27'd0, r.mem}, "mem op");
		check({24'd0, ctrl.br}, {24'd0, r.br}, "branch kind");
		// no row holds a trap, cop0, mult/div or hi/lo instruction
		check({22'd0, ctrl.mult, ctrl.div, ctrl.eret, ctrl.mtc0, ctrl.mfc0, ctrl.mthi,
			ctrl.mtlo, ctrl.syscall, ctrl.brk, ctrl.goto_hilo}, 32'd0, "trap and hi/lo flags");
		check(32'(next_delay_slot), 32'(r.nds), "next_delay_slot");
		if (!r.rnd)
			check(out.jr_target, r.jr, "jr_target");
		if (r.br[1]) // direct jump carries its index
			check({6'd0, out.j_index}, {6'd0, r.inst[25:0]}, "j_index");
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired before all rows were applied");
		$display("*** FAILED ***");
		$fatal(1, "timeout");
	end

	initial begin
		lfsr          = 32'heda5;
		held_ds       = 1'b0;
		arst_n        = 1'b0;
		stall         = 1'b0;
		clear         = 1'b0;
		inst_valid    = 1'b0;
		inst          = '0;
		if_pc         = '0;
		if_delay_slot = 1'b0;
		reg_rdata1    = '0;
		reg_rdata2    = '0;
		phase         = "reset";
		fill_table();
		repeat (RESET_CYCLES - 1) @(posedge clk);
		@(negedge clk);
		check(32'(inst_ack), 32'd0, "inst_ack");
		@(posedge clk);
		#DRIVE_DELAY arst_n = 1'b1;

		foreach (rows[i]) begin
			phase = $sformatf("row %0d", i);
			apply_row(rows[i]);
		end

		if (id_stage_inst.id_stage_asserts_inst.fail_count == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			$display("%0d assertion failures", id_stage_inst.id_stage_asserts_inst.fail_count);
			$display("*** FAILED ***");
			$fatal(1, "assertions failed");
		end
	end

endmodule

// ==== project.f ====
common/mips_id_pkg.sv
logic/inst_latch.sv
decode/inst_decoder.sv
decode/operand_select.sv
logic/id_stage.sv
verification/id_stage_asserts.sv
verification/id_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the id_stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -sv \
	--top-module id_stage_tb \
	--Mdir "$BUILD_DIR" \
	-o id_stage_sim \
	-f project.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/id_stage_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
fi

if grep -qxF '*** PASSED ***' "$LOG"; then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed, see $LOG"
exit 1
